// File: Makefile
TOP = camera_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module camera
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

# The sim target fails unless the pass message appears in the output

// File: camera.sv
module camera
    import camera_pkg::*;
(
    input  logic          clock_spi_in,
    input  logic          mipi_byte_reset_n,
    input  bayer_stream_t pixel_i,
    input  logic [7:0]    op_code_i,
    input  logic          op_code_valid_i,
    input  logic          operand_valid_i,
    input  logic [7:0]    operand_count_i,
    output logic [7:0]    response_o,
    output logic          response_valid_o
);

    rgb_stream_t debayered;
    rgb_stream_t cropped;
    logic        capture_active;
    logic [15:0] read_address;
    logic [7:0]  read_data;

    command_handler command_handler_i (
        .clock_spi_in          (clock_spi_in),
        .mipi_byte_reset_n     (mipi_byte_reset_n),
        .op_code_i             (op_code_i),
        .op_code_valid_i       (op_code_valid_i),
        .operand_valid_i       (operand_valid_i),
        .operand_count_i       (operand_count_i),
        .cropped_frame_valid_i (cropped.frame_valid),
        .read_data_i           (read_data),
        .capture_active_o      (capture_active),
        .read_address_o        (read_address),
        .response_o            (response_o),
        .response_valid_o      (response_valid_o)
    );

    debayer debayer_i (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (pixel_i),
        .pixel_o           (debayered)
    );

    crop crop_i (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (debayered),
        .pixel_o           (cropped)
    );

    image_buffer image_buffer_i (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (cropped),
        .capture_active_i  (capture_active),
        .read_address_i    (read_address),
        .read_data_o       (read_data)
    );

endmodule

// File: camera_pkg.sv
package camera_pkg;

    // Raw Bayer pixel stream from the sensor side
    typedef struct packed {
        logic       frame_valid;
        logic       line_valid;
        logic [9:0] data;
    } bayer_stream_t;

    // Full colour pixel stream after debayering
    typedef struct packed {
        logic       frame_valid;
        logic       line_valid;
        logic [9:0] red;
        logic [9:0] green;
        logic [9:0] blue;
    } rgb_stream_t;

    // Two bytes of a count, as returned to the host
    typedef struct packed {
        logic [7:0] high;
        logic [7:0] low;
    } byte_pair_t;

    // Remaining byte count, read whole or one byte at a time
    typedef union packed {
        logic [15:0] count;
        byte_pair_t  bytes;
    } byte_count_u;

endpackage

// File: camera_settings.svh
`ifndef CAMERA_SETTINGS_SVH
`define CAMERA_SETTINGS_SVH

// Raw sensor frame size
`define SENSOR_WIDTH 16
`define SENSOR_HEIGHT 12

// Crop window in debayered coordinates, end is exclusive
`define CROP_X_START 4
`define CROP_X_END 12
`define CROP_Y_START 2
`define CROP_Y_END 10

// Bytes per capture, also the image buffer depth
`define CAPTURE_SIZE ((`CROP_X_END - `CROP_X_START) * (`CROP_Y_END - `CROP_Y_START))

// Host op codes
`define OP_CAPTURE 8'h20
`define OP_BYTES_AVAILABLE 8'h21
`define OP_READ_DATA 8'h22

`endif

// File: camera_tb.sv
`include "camera_settings.svh"

module camera_tb
    import camera_pkg::*;
();

    localparam int LINE_BLANK = 4;
    localparam int FRAME_BLANK = 8;
    localparam int LINE_CYCLES = `SENSOR_WIDTH + LINE_BLANK;
    localparam int FRAME_CYCLES = 2 * FRAME_BLANK + `SENSOR_HEIGHT * LINE_CYCLES + 2;
    // Three full buffer reads with two count queries per byte
    localparam int READ_CYCLES = 3 * `CAPTURE_SIZE * 40;
    localparam int TIMEOUT_CYCLES = 10 * FRAME_CYCLES + READ_CYCLES;

    typedef struct packed {
        logic [9:0] red;
        logic [9:0] green;
        logic [9:0] blue;
    } colour_t;

    logic          clock_spi_in;
    logic          mipi_byte_reset_n;
    bayer_stream_t pixel;
    logic [7:0]    op_code;
    logic          op_code_valid;
    logic          operand_valid;
    logic [7:0]    operand_count;
    logic [7:0]    response;
    logic          response_valid;
    integer        seed;
    colour_t       colour_a;
    colour_t       colour_b;
    colour_t       colour_c;
    colour_t       colour_d;

    tb_clock_gen #(.PERIOD(20)) clock_gen_i (.clock_o(clock_spi_in));

    camera dut_i (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (pixel),
        .op_code_i         (op_code),
        .op_code_valid_i   (op_code_valid),
        .operand_valid_i   (operand_valid),
        .operand_count_i   (operand_count),
        .response_o        (response),
        .response_valid_o  (response_valid)
    );

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual == expected) else begin
            $display("Fail %s expected %0h actual %0h", name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // RGB332 from the top bits of each channel
    function automatic logic [7:0] pack_rgb332(input colour_t colour);
        return {colour.red[9:7], colour.green[9:7], colour.blue[9:8]};
    endfunction

    // RGGB site value where even rows start with red
    function automatic logic [9:0] site_value(input colour_t colour, input int row,
                                              input int col);
        case ({row[0], col[0]})
            2'b00: return colour.red;
            2'b11: return colour.blue;
            default: return colour.green;
        endcase
    endfunction

    task automatic pick_colour(input logic [7:0] avoid, output colour_t colour);
        logic [31:0] value;
        do begin
            value = $random(seed);
            colour.red = value[9:0];
            value = $random(seed);
            colour.green = value[9:0];
            value = $random(seed);
            colour.blue = value[9:0];
        end while (pack_rgb332(colour) == avoid);
    endtask

    task automatic send_frame(input colour_t colour);
        int row;
        int col;
        @(posedge clock_spi_in);
        pixel.frame_valid <= 1'b1;
        repeat (FRAME_BLANK) @(posedge clock_spi_in);
        for (row = 0; row < `SENSOR_HEIGHT; row++) begin
            for (col = 0; col < `SENSOR_WIDTH; col++) begin
                pixel.line_valid <= 1'b1;
                pixel.data <= site_value(colour, row, col);
                @(posedge clock_spi_in);
            end
            pixel.line_valid <= 1'b0;
            pixel.data <= 10'd0;
            repeat (LINE_BLANK) @(posedge clock_spi_in);
        end
        pixel.frame_valid <= 1'b0;
        repeat (FRAME_BLANK) @(posedge clock_spi_in);
    endtask

    // One op code transfer with an optional operand strobe before release
    task automatic run_op(input logic [7:0] code, input logic [7:0] count,
                          input logic strobe, output logic [7:0] data);
        @(posedge clock_spi_in);
        op_code <= code;
        operand_count <= count;
        op_code_valid <= 1'b1;
        @(negedge clock_spi_in);
        check_value("response valid rise delay", 16'd0, 16'(response_valid));
        @(negedge clock_spi_in);
        check_value("response valid rise", 16'd1, 16'(response_valid));
        @(negedge clock_spi_in);
        data = response;
        if (strobe) begin
            @(posedge clock_spi_in);
            operand_valid <= 1'b1;
        end
        @(posedge clock_spi_in);
        operand_valid <= 1'b0;
        op_code_valid <= 1'b0;
        @(negedge clock_spi_in);
        check_value("response valid fall delay", 16'd1, 16'(response_valid));
        @(negedge clock_spi_in);
        check_value("response valid fall", 16'd0, 16'(response_valid));
    endtask

    task automatic request_capture();
        logic [7:0] data;
        run_op(`OP_CAPTURE, 8'd0, 1'b0, data);
    endtask

    task automatic check_available(input int expected, input string name);
        logic [7:0] data;
        run_op(`OP_BYTES_AVAILABLE, 8'd0, 1'b0, data);
        check_value({name, " high byte"}, 16'(expected >> 8), 16'(data));
        run_op(`OP_BYTES_AVAILABLE, 8'd1, 1'b0, data);
        check_value({name, " low byte"}, 16'(expected & 255), 16'(data));
    endtask

    // Every byte must match and the count must drop after each strobe
    task automatic read_buffer(input colour_t colour, input string name);
        logic [7:0] data;
        int index;
        for (index = 0; index < `CAPTURE_SIZE; index++) begin
            run_op(`OP_READ_DATA, 8'd0, 1'b1, data);
            check_value(name, 16'(pack_rgb332(colour)), 16'(data));
            check_available(`CAPTURE_SIZE - index - 1, {name, " count"});
        end
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock_spi_in);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        seed = 32'hb8e5_8fe3;
        mipi_byte_reset_n <= 1'b0;
        pixel <= '0;
        op_code <= 8'd0;
        op_code_valid <= 1'b0;
        operand_valid <= 1'b0;
        operand_count <= 8'd0;
        repeat (16) @(posedge clock_spi_in);
        mipi_byte_reset_n <= 1'b1;

        @(negedge clock_spi_in);
        check_value("reset response valid", 16'd0, 16'(response_valid));
        check_available(`CAPTURE_SIZE, "reset count");

        // Plain capture of one frame
        pick_colour(8'h00, colour_a);
        request_capture();
        send_frame(colour_a);
        read_buffer(colour_a, "first capture");

        // Frame with no request leaves the buffer alone
        pick_colour(pack_rgb332(colour_a), colour_b);
        send_frame(colour_b);
        request_capture();
        check_available(`CAPTURE_SIZE, "count after new request");
        read_buffer(colour_a, "frame without request");

        // Pending request takes frame C while the one made mid capture is dropped
        pick_colour(pack_rgb332(colour_a), colour_c);
        pick_colour(pack_rgb332(colour_c), colour_d);
        fork
            send_frame(colour_c);
            begin
                repeat (FRAME_BLANK + 6 * LINE_CYCLES) @(posedge clock_spi_in);
                request_capture();
            end
        join
        // The dropped request must not restart the read count
        check_available(0, "count after ignored request");
        send_frame(colour_d);
        request_capture();
        read_buffer(colour_c, "request during capture");

        $display("All checks passed");
        $finish;
    end

endmodule

// File: command_handler.sv
`include "camera_settings.svh"

module command_handler
    import camera_pkg::*;
(
    input  logic        clock_spi_in,
    input  logic        mipi_byte_reset_n,
    input  logic [7:0]  op_code_i,
    input  logic        op_code_valid_i,
    input  logic        operand_valid_i,
    input  logic [7:0]  operand_count_i,
    input  logic        cropped_frame_valid_i,
    input  logic [7:0]  read_data_i,
    output logic        capture_active_o,
    output logic [15:0] read_address_o,
    output logic [7:0]  response_o,
    output logic        response_valid_o
);

    logic        capture_flag;
    logic        frame_valid_q;
    logic [1:0]  frame_valid_edge;
    logic [15:0] bytes_read;
    logic        operand_valid_q;
    logic        operand_rise;
    byte_count_u remaining;

    assign remaining.count = 16'(`CAPTURE_SIZE) - bytes_read;
    assign read_address_o = bytes_read;

    // Previous and current frame valid
    assign frame_valid_edge = {frame_valid_q, cropped_frame_valid_i};

    assign operand_rise = operand_valid_i && !operand_valid_q;

    // Capture window follows the cropped frame
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
            capture_active_o <= 1'b0;
        end else begin
            frame_valid_q <= cropped_frame_valid_i;

            if (capture_flag && frame_valid_edge == 2'b01) begin
                capture_active_o <= 1'b1;
            end

            if (frame_valid_edge == 2'b10) begin
                capture_active_o <= 1'b0;
            end
        end
    end

    // Op code decode
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            capture_flag <= 1'b0;
            bytes_read <= 16'd0;
            operand_valid_q <= 1'b0;
            response_o <= 8'd0;
            response_valid_o <= 1'b0;
        end else begin
            operand_valid_q <= operand_valid_i;
            response_valid_o <= op_code_valid_i;

            // Request is consumed once the capture has started
            if (capture_active_o) begin
                capture_flag <= 1'b0;
            end

            if (op_code_valid_i) begin
                case (op_code_i)
                    `OP_CAPTURE: begin
                        if (!capture_active_o) begin
                            capture_flag <= 1'b1;
                            bytes_read <= 16'd0;
                        end
                    end

                    `OP_BYTES_AVAILABLE: begin
                        case (operand_count_i)
                            8'd0: response_o <= remaining.bytes.high;
                            8'd1: response_o <= remaining.bytes.low;
                            default: response_o <= response_o;
                        endcase
                    end

                    `OP_READ_DATA: begin
                        response_o <= read_data_i;

                        // One byte consumed per operand strobe
                        if (operand_rise) begin
                            bytes_read <= bytes_read + 16'd1;
                        end
                    end

                    default: begin
                        response_o <= response_o;
                    end
                endcase
            end
        end
    end

endmodule

// File: crop.sv
`include "camera_settings.svh"

module crop
    import camera_pkg::*;
(
    input  logic        clock_spi_in,
    input  logic        mipi_byte_reset_n,
    input  rgb_stream_t pixel_i,
    output rgb_stream_t pixel_o
);

    localparam int X_W = $clog2(`SENSOR_WIDTH);
    localparam int Y_W = $clog2(`SENSOR_HEIGHT + 1);

    logic [X_W-1:0] x_count;
    logic [Y_W-1:0] y_count;
    logic           line_valid_q;
    logic           in_rows;
    logic           in_window;

    assign in_rows = y_count >= Y_W'(`CROP_Y_START) && y_count < Y_W'(`CROP_Y_END);
    assign in_window = pixel_i.frame_valid && pixel_i.line_valid && in_rows &&
                       x_count >= X_W'(`CROP_X_START) && x_count < X_W'(`CROP_X_END);

    // Column and row position of the input stream
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            line_valid_q <= 1'b0;
        end else begin
            x_count <= pixel_i.line_valid ? x_count + 1'b1 : '0;
            line_valid_q <= pixel_i.line_valid;

            if (!pixel_i.frame_valid) begin
                y_count <= '0;
            end else if (line_valid_q && !pixel_i.line_valid) begin
                y_count <= y_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            pixel_o <= '0;
        end else begin
            // Frame opens on the first window line and closes past the last
            pixel_o.frame_valid <= pixel_i.frame_valid && in_rows &&
                                   (pixel_o.frame_valid || pixel_i.line_valid);
            pixel_o.line_valid <= in_window;
            pixel_o.red <= pixel_i.red;
            pixel_o.green <= pixel_i.green;
            pixel_o.blue <= pixel_i.blue;
        end
    end

endmodule

// File: debayer.sv
`include "camera_settings.svh"

module debayer
    import camera_pkg::*;
(
    input  logic          clock_spi_in,
    input  logic          mipi_byte_reset_n,
    input  bayer_stream_t pixel_i,
    output rgb_stream_t   pixel_o
);

    localparam int X_W = $clog2(`SENSOR_WIDTH);
    localparam int Y_W = $clog2(`SENSOR_HEIGHT + 1);
    localparam logic [X_W-1:0] X_LAST = X_W'(`SENSOR_WIDTH - 1);

    logic [X_W-1:0] x_count;
    logic [Y_W-1:0] y_count;

    // Previous line of raw samples
    logic [9:0] line_buffer [`SENSOR_WIDTH];

    // 2x2 window around the incoming sample
    logic [9:0] current;
    logic [9:0] left_pixel;
    logic [9:0] above;
    logic [9:0] above_left;

    logic [9:0]  red;
    logic [9:0]  blue;
    logic [10:0] green_sum;
    logic        line_valid_out;

    assign current = pixel_i.data;
    assign above = line_buffer[x_count];

    // Bayer phase from row and column parity, even rows start with R
    always_comb begin
        case ({y_count[0], x_count[0]})
            2'b00: begin
                red = current;
                blue = above_left;
                green_sum = {1'b0, left_pixel} + {1'b0, above};
            end
            2'b01: begin
                red = left_pixel;
                blue = above;
                green_sum = {1'b0, current} + {1'b0, above_left};
            end
            2'b10: begin
                red = above;
                blue = left_pixel;
                green_sum = {1'b0, current} + {1'b0, above_left};
            end
            default: begin
                red = above_left;
                blue = current;
                green_sum = {1'b0, left_pixel} + {1'b0, above};
            end
        endcase
    end

    // First row and first column have no full window
    assign line_valid_out = pixel_i.line_valid && x_count != '0 && y_count != '0;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else begin
            x_count <= pixel_i.line_valid ? x_count + 1'b1 : '0;

            if (!pixel_i.frame_valid) begin
                y_count <= '0;
            end else if (pixel_i.line_valid && x_count == X_LAST) begin
                y_count <= y_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (pixel_i.line_valid) begin
            line_buffer[x_count] <= current;
            left_pixel <= current;
            above_left <= above;
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            pixel_o <= '0;
        end else begin
            pixel_o.frame_valid <= pixel_i.frame_valid;
            pixel_o.line_valid <= line_valid_out;
            pixel_o.red <= red;
            pixel_o.green <= green_sum[10:1];
            pixel_o.blue <= blue;
        end
    end

endmodule

// File: image_buffer.sv
`include "camera_settings.svh"

module image_buffer
    import camera_pkg::*;
(
    input  logic        clock_spi_in,
    input  logic        mipi_byte_reset_n,
    input  rgb_stream_t pixel_i,
    input  logic        capture_active_i,
    input  logic [15:0] read_address_i,
    output logic [7:0]  read_data_o
);

    localparam int ADDR_W = $clog2(`CAPTURE_SIZE);

    logic [ADDR_W-1:0] write_address;
    logic [7:0]        write_data;
    logic              write_enable;
    logic              pixel_valid;
    logic              read_in_range;

    logic [7:0] memory [`CAPTURE_SIZE];

    assign pixel_valid = pixel_i.frame_valid && pixel_i.line_valid;
    assign write_enable = pixel_valid && capture_active_i;

    // RGB332 packing
    assign write_data = {pixel_i.red[9:7], pixel_i.green[9:7], pixel_i.blue[9:8]};

    assign read_in_range = read_address_i < 16'(`CAPTURE_SIZE);

    // Write address restarts at every frame
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            write_address <= '0;
        end else if (!pixel_i.frame_valid) begin
            write_address <= '0;
        end else if (pixel_valid) begin
            write_address <= write_address + 1'b1;
        end
    end

    // Single port, a write blocks the read in that cycle
    always_ff @(posedge clock_spi_in) begin
        if (write_enable) begin
            memory[write_address] <= write_data;
        end else if (read_in_range) begin
            read_data_o <= memory[read_address_i[ADDR_W-1:0]];
        end else begin
            read_data_o <= 8'h00;
        end
    end

endmodule

// File: list.f
+incdir+.
camera_pkg.sv
command_handler.sv
debayer.sv
crop.sv
image_buffer.sv
camera.sv
tb_clock_gen.sv
camera_tb.sv

// File: tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clock_o
);

    initial begin
        clock_o = 1'b0;
    end

    // Free running, half period high and half low
    always #(PERIOD / 2) clock_o = ~clock_o;

endmodule
